//--- all.f
+incdir+test
design/nf_map_pkg.sv
design/nf_periph_pkg.sv
design/nf_bus_decode.sv
design/nf_ram.sv
design/nf_gpio.sv
design/nf_pwm.sv
design/nf_bus_result.sv
design/nf_periph_top.sv
test/nf_periph_tb.sv

//--- design/nf_bus_decode.sv
`timescale 1ns/100ps

module nf_bus_decode
(
    input   logic                                   clk,            // clock
    input   logic                                   reset_i,        // sync reset
    input   logic   [31 : 0]                        addr_i,         // request address
    input   logic   [31 : 0]                        wd_i,           // request write data
    input   logic                                   we_i,           // write enable
    input   logic                                   req_i,          // request strobe
    output  logic                                   acc_valid_o,    // access strobe
    output  logic   [nf_map_pkg::slave_c-1 : 0]     acc_sel_o,      // one-hot slave select
    output  logic                                   acc_we_o,       // registered write enable
    output  logic   [31 : 0]                        acc_addr_o,     // registered address
    output  logic   [31 : 0]                        acc_wd_o        // registered write data
);

    logic   [nf_map_pkg::region_w-1 : 0]    region;                 // region field of addr_i
    logic   [nf_map_pkg::slave_c-1 : 0]     sel_dec;                // decoded select

    assign region = addr_i[nf_map_pkg::region_msb : nf_map_pkg::region_lsb];

    always_comb begin
        sel_dec = '0;                                               // unmapped by default
        case (region)
            nf_map_pkg::region_ram  : sel_dec[nf_map_pkg::sel_ram]  = 1'b1;
            nf_map_pkg::region_gpio : sel_dec[nf_map_pkg::sel_gpio] = 1'b1;
            nf_map_pkg::region_pwm  : sel_dec[nf_map_pkg::sel_pwm]  = 1'b1;
            default                 : sel_dec = '0;                 // error path in result
        endcase
    end

    // control half of the stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_valid_o <= 1'b0;
            acc_sel_o   <= '0;
        end else begin
            acc_valid_o <= req_i;                                   // one stage per request
            acc_sel_o   <= sel_dec;
        end
    end

    // request payload follows the strobe
    always_ff @(posedge clk) begin
        acc_we_o    <= we_i;
        acc_addr_o  <= addr_i;
        acc_wd_o    <= wd_i;
    end

endmodule : nf_bus_decode

//--- design/nf_bus_result.sv
`timescale 1ns/100ps

module nf_bus_result
(
    input   logic                                   clk,            // clock
    input   logic                                   reset_i,        // sync reset
    input   logic                                   acc_valid_i,    // access strobe
    input   logic   [nf_map_pkg::slave_c-1 : 0]     acc_sel_i,      // one-hot slave select
    input   logic                                   acc_we_i,       // write enable
    input   logic   [31 : 0]                        ram_rd_i,       // RAM read data
    input   logic   [31 : 0]                        gpio_rd_i,      // GPIO read data
    input   logic   [31 : 0]                        pwm_rd_i,       // PWM read data
    output  logic   [31 : 0]                        rd_o,           // read data to requester
    output  logic                                   req_ack_o,      // acknowledge
    output  logic                                   resp_err_o      // unmapped access
);

    logic                                   valid_d;                // lined up with slave rd
    logic   [nf_map_pkg::slave_c-1 : 0]     sel_d;
    logic                                   we_d;
    logic   [31 : 0]                        rd_mux;                 // one-hot and-or mux

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_d <= 1'b0;
            sel_d   <= '0;
            we_d    <= 1'b0;
        end else begin
            valid_d <= acc_valid_i;
            sel_d   <= acc_sel_i;
            we_d    <= acc_we_i;
        end
    end

    assign rd_mux = ( {32{sel_d[nf_map_pkg::sel_ram]}}  & ram_rd_i  )
                  | ( {32{sel_d[nf_map_pkg::sel_gpio]}} & gpio_rd_i )
                  | ( {32{sel_d[nf_map_pkg::sel_pwm]}}  & pwm_rd_i  );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_ack_o  <= 1'b0;
            resp_err_o <= 1'b0;
            rd_o       <= '0;
        end else begin
            req_ack_o  <= valid_d;                                  // one pulse per request
            resp_err_o <= valid_d & ~(|sel_d);                      // no slave hit
            rd_o       <= (valid_d && !we_d) ? rd_mux : '0;         // writes return zero
        end
    end

endmodule : nf_bus_result

//--- design/nf_gpio.sv
`timescale 1ns/100ps

module nf_gpio
(
    input   logic                                   clk,            // clock
    input   logic                                   reset_i,        // sync reset
    input   logic                                   sel_i,          // slave selected, valid
    input   logic                                   we_i,           // write enable
    input   logic   [31 : 0]                        addr_i,         // byte address
    input   logic   [31 : 0]                        wd_i,           // write data
    input   logic   [nf_periph_pkg::gpio_w-1 : 0]   gpi_i,          // input pins
    output  logic   [nf_periph_pkg::gpio_w-1 : 0]   gpo_o,          // output register
    output  logic   [nf_periph_pkg::gpio_w-1 : 0]   gpd_o,          // direction register
    output  logic   [31 : 0]                        rd_o            // registered read data
);

    logic   [nf_periph_pkg::reg_off_w-1 : 0]    reg_off;            // register offset
    logic   [31 : 0]                            rd_sel;             // addressed register
    logic                                       wr_en;              // selected write
    logic                                       rd_en;              // selected read

    assign reg_off = addr_i[nf_periph_pkg::reg_off_msb : nf_periph_pkg::reg_off_lsb];
    assign wr_en   = sel_i & we_i;
    assign rd_en   = sel_i & ~we_i;

    // zero extended read mux
    always_comb begin
        case (reg_off)
            nf_periph_pkg::gpio_reg_gpi : rd_sel = 32'(gpi_i);      // pins taken as they are
            nf_periph_pkg::gpio_reg_gpo : rd_sel = 32'(gpo_o);
            nf_periph_pkg::gpio_reg_gpd : rd_sel = 32'(gpd_o);
            default                     : rd_sel = '0;              // offset 3
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            gpo_o <= '0;                                            // all pins low
            gpd_o <= '0;                                            // all pins input
        end else if (wr_en) begin
            if (reg_off == nf_periph_pkg::gpio_reg_gpo) begin
                gpo_o <= wd_i[nf_periph_pkg::gpio_w-1 : 0];         // low bits only
            end
            if (reg_off == nf_periph_pkg::gpio_reg_gpd) begin
                gpd_o <= wd_i[nf_periph_pkg::gpio_w-1 : 0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_o <= rd_sel;                                         // hold between reads
        end
    end

endmodule : nf_gpio

//--- design/nf_map_pkg.sv
package nf_map_pkg;

    // region field of the byte address
    localparam int                      region_lsb  = 16;       // low bit of region field
    localparam int                      region_msb  = 19;       // high bit of region field
    localparam int                      region_w    = region_msb - region_lsb + 1;

    // region codes, anything else is unmapped
    localparam logic [region_w-1 : 0]   region_ram  = 4'h0;     // 0x0000_xxxx
    localparam logic [region_w-1 : 0]   region_gpio = 4'h1;     // 0x0001_xxxx
    localparam logic [region_w-1 : 0]   region_pwm  = 4'h2;     // 0x0002_xxxx

    // one-hot slave select layout
    localparam int                      slave_c     = 3;        // ram, gpio, pwm
    localparam int                      sel_ram     = 0;        // select bit of RAM
    localparam int                      sel_gpio    = 1;        // select bit of GPIO
    localparam int                      sel_pwm     = 2;        // select bit of PWM

endpackage : nf_map_pkg

//--- design/nf_periph_pkg.sv
package nf_periph_pkg;

    // RAM slave geometry
    localparam int  ram_depth   = 256;                          // words
    localparam int  ram_aw      = 8;                            // word address width
    localparam int  ram_lsb     = 2;                            // word aligned
    localparam int  ram_msb     = ram_lsb + ram_aw - 1;         // bit 9, bits above alias

    // pin widths
    localparam int  gpio_w      = 8;                            // gpio port width
    localparam int  pwm_w       = 8;                            // counter and duty width

    // register offset field inside a slave
    localparam int  reg_off_lsb = 2;                            // word aligned registers
    localparam int  reg_off_msb = 3;
    localparam int  reg_off_w   = reg_off_msb - reg_off_lsb + 1;

    // GPIO register map
    // offset 3 is not decoded and reads back zero
    localparam logic [reg_off_w-1 : 0]  gpio_reg_gpi = 2'd0;    // sampled input pins
    localparam logic [reg_off_w-1 : 0]  gpio_reg_gpo = 2'd1;    // output value
    localparam logic [reg_off_w-1 : 0]  gpio_reg_gpd = 2'd2;    // pin direction

    // PWM register map
    localparam logic [reg_off_w-1 : 0]  pwm_reg_duty = 2'd0;    // duty, other offsets read 0

endpackage : nf_periph_pkg

//--- design/nf_periph_top.sv
`timescale 1ns/100ps

module nf_periph_top
(
    input   logic                                   clk,            // clock
    input   logic                                   reset_i,        // sync reset
    input   logic   [31 : 0]                        addr_i,         // request address
    input   logic   [31 : 0]                        wd_i,           // request write data
    input   logic                                   we_i,           // write enable
    input   logic                                   req_i,          // request strobe
    input   logic   [nf_periph_pkg::gpio_w-1 : 0]   gpio_i,         // GPIO input pins
    output  logic   [31 : 0]                        rd_o,           // read data
    output  logic                                   req_ack_o,      // acknowledge
    output  logic                                   resp_err_o,     // unmapped access
    output  logic   [nf_periph_pkg::gpio_w-1 : 0]   gpio_o,         // GPIO output pins
    output  logic   [nf_periph_pkg::gpio_w-1 : 0]   gpio_d_o,       // GPIO direction
    output  logic                                   pwm_o           // PWM output
);

    // decoded access stage
    logic                                   acc_valid;
    logic   [nf_map_pkg::slave_c-1 : 0]     acc_sel;
    logic                                   acc_we;
    logic   [31 : 0]                        acc_addr;
    logic   [31 : 0]                        acc_wd;
    // slave side
    logic                                   ram_sel;                // gated selects
    logic                                   gpio_sel;
    logic                                   pwm_sel;
    logic   [31 : 0]                        ram_rd;
    logic   [31 : 0]                        gpio_rd;
    logic   [31 : 0]                        pwm_rd;

    assign ram_sel  = acc_valid & acc_sel[nf_map_pkg::sel_ram];
    assign gpio_sel = acc_valid & acc_sel[nf_map_pkg::sel_gpio];
    assign pwm_sel  = acc_valid & acc_sel[nf_map_pkg::sel_pwm];

    nf_bus_decode decode0
    (
        .clk            ( clk           ),      // clock
        .reset_i        ( reset_i       ),      // reset
        .addr_i         ( addr_i        ),      // core address
        .wd_i           ( wd_i          ),      // core write data
        .we_i           ( we_i          ),      // core write enable
        .req_i          ( req_i         ),      // core request
        .acc_valid_o    ( acc_valid     ),      // access strobe
        .acc_sel_o      ( acc_sel       ),      // one-hot select
        .acc_we_o       ( acc_we        ),
        .acc_addr_o     ( acc_addr      ),
        .acc_wd_o       ( acc_wd        )
    );

    nf_ram ram0
    (
        .clk            ( clk           ),
        .sel_i          ( ram_sel       ),      // region 0
        .we_i           ( acc_we        ),
        .addr_i         ( acc_addr      ),
        .wd_i           ( acc_wd        ),
        .rd_o           ( ram_rd        )
    );

    nf_gpio gpio0
    (
        .clk            ( clk           ),
        .reset_i        ( reset_i       ),
        .sel_i          ( gpio_sel      ),      // region 1
        .we_i           ( acc_we        ),
        .addr_i         ( acc_addr      ),
        .wd_i           ( acc_wd        ),
        .gpi_i          ( gpio_i        ),      // pins in
        .gpo_o          ( gpio_o        ),      // pins out
        .gpd_o          ( gpio_d_o      ),      // pin direction
        .rd_o           ( gpio_rd       )
    );

    nf_pwm pwm0
    (
        .clk            ( clk           ),
        .reset_i        ( reset_i       ),
        .sel_i          ( pwm_sel       ),      // region 2
        .we_i           ( acc_we        ),
        .addr_i         ( acc_addr      ),
        .wd_i           ( acc_wd        ),
        .pwm_o          ( pwm_o         ),      // pwm pin
        .rd_o           ( pwm_rd        )
    );

    nf_bus_result result0
    (
        .clk            ( clk           ),
        .reset_i        ( reset_i       ),
        .acc_valid_i    ( acc_valid     ),
        .acc_sel_i      ( acc_sel       ),
        .acc_we_i       ( acc_we        ),
        .ram_rd_i       ( ram_rd        ),
        .gpio_rd_i      ( gpio_rd       ),
        .pwm_rd_i       ( pwm_rd        ),
        .rd_o           ( rd_o          ),      // back to core
        .req_ack_o      ( req_ack_o     ),
        .resp_err_o     ( resp_err_o    )
    );

endmodule : nf_periph_top

//--- design/nf_pwm.sv
`timescale 1ns/100ps

module nf_pwm
(
    input   logic               clk,                                // clock
    input   logic               reset_i,                            // sync reset
    input   logic               sel_i,                              // slave selected, valid
    input   logic               we_i,                               // write enable
    input   logic   [31 : 0]    addr_i,                             // byte address
    input   logic   [31 : 0]    wd_i,                               // write data
    output  logic               pwm_o,                              // pwm output pin
    output  logic   [31 : 0]    rd_o                                // registered read data
);

    logic   [nf_periph_pkg::pwm_w-1 : 0]        duty;               // high time in cycles
    logic   [nf_periph_pkg::pwm_w-1 : 0]        cnt;                // free running counter
    logic   [nf_periph_pkg::reg_off_w-1 : 0]    reg_off;            // register offset
    logic                                       duty_hit;           // offset is duty

    assign reg_off  = addr_i[nf_periph_pkg::reg_off_msb : nf_periph_pkg::reg_off_lsb];
    assign duty_hit = (reg_off == nf_periph_pkg::pwm_reg_duty);

    // duty register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            duty <= '0;                                             // output held low
        end else if (sel_i && we_i && duty_hit) begin
            duty <= wd_i[nf_periph_pkg::pwm_w-1 : 0];               // low bits only
        end
    end

    // counter and compare
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt   <= '0;
            pwm_o <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;                                    // wraps every 256 cycles
            pwm_o <= (cnt < duty);                                  // duty highs per period
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i && !we_i) begin
            rd_o <= duty_hit ? 32'(duty) : '0;                      // zero extended duty
        end
    end

endmodule : nf_pwm

//--- design/nf_ram.sv
`timescale 1ns/100ps

module nf_ram
(
    input   logic               clk,                                // clock
    input   logic               sel_i,                              // slave selected, valid
    input   logic               we_i,                               // write enable
    input   logic   [31 : 0]    addr_i,                             // byte address
    input   logic   [31 : 0]    wd_i,                               // write data
    output  logic   [31 : 0]    rd_o                                // registered read data
);

    logic   [31 : 0]                        mem [0 : nf_periph_pkg::ram_depth-1];
    logic   [nf_periph_pkg::ram_aw-1 : 0]   word_addr;              // word index

    // bits above ram_msb are ignored so the array repeats in its region
    assign word_addr = addr_i[nf_periph_pkg::ram_msb : nf_periph_pkg::ram_lsb];

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (we_i) begin
                mem[word_addr] <= wd_i;                             // store word
            end
            rd_o <= mem[word_addr];                                 // old contents
        end
    end

endmodule : nf_ram

//--- run.sh
#!/usr/bin/env bash
# build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f all.f --top-module nf_periph_tb -o nf_periph_sim; then
    echo "verilator build failed"
    exit 1
fi

if [ ! -x obj_dir/nf_periph_sim ]; then
    echo "simulation binary not found"
    exit 1
fi

./obj_dir/nf_periph_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit "$status"

//--- test/nf_periph_model.svh
`ifndef NF_PERIPH_MODEL_SVH
`define NF_PERIPH_MODEL_SVH

// slave state as the requester expects it, updated in request order
logic   [31 : 0]                        model_ram [0 : nf_periph_pkg::ram_depth-1];
logic   [nf_periph_pkg::gpio_w-1 : 0]   model_gpo;              // output register
logic   [nf_periph_pkg::gpio_w-1 : 0]   model_gpd;              // direction register
logic   [nf_periph_pkg::gpio_w-1 : 0]   model_gpi;              // value held on gpio_i
logic   [nf_periph_pkg::pwm_w-1 : 0]    model_duty;             // duty register
logic   [31 : 0]                        exp_rd_q [$];           // expected rd_o per request
logic                                   exp_err_q [$];          // expected resp_err_o

// reads see every earlier write, so predicting at issue time is enough
task automatic predict_access(input logic [31:0] addr, input logic we, input logic [31:0] wd);
    logic   [nf_map_pkg::region_w-1 : 0]    region;
    logic   [nf_periph_pkg::reg_off_w-1 : 0] off;
    logic   [nf_periph_pkg::ram_aw-1 : 0]   word;
    logic   [31 : 0]                        rd;
    logic                                   err;
    region = addr[nf_map_pkg::region_msb : nf_map_pkg::region_lsb];
    off    = addr[nf_periph_pkg::reg_off_msb : nf_periph_pkg::reg_off_lsb];
    word   = addr[nf_periph_pkg::ram_msb : nf_periph_pkg::ram_lsb];     // upper bits alias
    rd     = '0;                                                // writes return zero
    err    = 1'b0;
    if (region == nf_map_pkg::region_ram) begin
        if (we) model_ram[word] = wd;
        else    rd = model_ram[word];
    end else if (region == nf_map_pkg::region_gpio) begin
        if (we) begin
            if (off == nf_periph_pkg::gpio_reg_gpo) model_gpo = wd[nf_periph_pkg::gpio_w-1 : 0];
            if (off == nf_periph_pkg::gpio_reg_gpd) model_gpd = wd[nf_periph_pkg::gpio_w-1 : 0];
        end else if (off == nf_periph_pkg::gpio_reg_gpi) rd = 32'(model_gpi);
        else if (off == nf_periph_pkg::gpio_reg_gpo)     rd = 32'(model_gpo);
        else if (off == nf_periph_pkg::gpio_reg_gpd)     rd = 32'(model_gpd);
    end else if (region == nf_map_pkg::region_pwm) begin
        if (off == nf_periph_pkg::pwm_reg_duty) begin
            if (we) model_duty = wd[nf_periph_pkg::pwm_w-1 : 0];
            else    rd = 32'(model_duty);
        end
    end else begin
        err = 1'b1;                                             // unmapped, no state change
    end
    exp_rd_q.push_back(rd);
    exp_err_q.push_back(err);
endtask

`endif

//--- test/nf_periph_tb.sv
`timescale 1ns/100ps

module nf_periph_tb;

    localparam logic [31 : 0]   lfsr_seed  = 32'd97961;
    localparam logic [31 : 0]   lfsr_taps  = 32'h8020_0003;     // x^32 + x^22 + x^2 + x + 1
    localparam int              ack_lat    = 3;                 // rising edges req_i to ack
    localparam int              wait_limit = 64;                // cycles before a wait gives up
    localparam logic [31 : 0]   gpio_base  = 32'h0001_0000;
    localparam logic [31 : 0]   pwm_base   = 32'h0002_0000;

    logic                                   clk;
    logic                                   reset_i;
    logic   [31 : 0]                        addr_i;
    logic   [31 : 0]                        wd_i;
    logic                                   we_i;
    logic                                   req_i;
    logic   [nf_periph_pkg::gpio_w-1 : 0]   gpio_i;
    logic   [31 : 0]                        rd_o;
    logic                                   req_ack_o;
    logic                                   resp_err_o;
    logic   [nf_periph_pkg::gpio_w-1 : 0]   gpio_o;
    logic   [nf_periph_pkg::gpio_w-1 : 0]   gpio_d_o;
    logic                                   pwm_o;
    logic   [31 : 0]                        lfsr_state;
    int                                     cyc;                // falling edges seen
    int                                     req_cnt;
    int                                     ack_cnt;
    int                                     issue_q [$];        // edge at which req_i was seen

    `include "nf_periph_model.svh"

    nf_periph_top dut0 (
        .clk(clk), .reset_i(reset_i), .addr_i(addr_i), .wd_i(wd_i), .we_i(we_i),
        .req_i(req_i), .gpio_i(gpio_i), .rd_o(rd_o), .req_ack_o(req_ack_o),
        .resp_err_o(resp_err_o), .gpio_o(gpio_o), .gpio_d_o(gpio_d_o), .pwm_o(pwm_o)
    );

    always #20 clk = ~clk;                                      // 40 ns period

    function automatic logic next_rand_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) lfsr_state = lfsr_state ^ lfsr_taps;       // galois feedback
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31 : 0] r;
        int            k;
        r = '0;
        for (k = 0; k < n; k++) r = {r[30:0], next_rand_bit()};
        return r;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp)
            stop_with_error($sformatf("MISMATCH %s actual=0x%08h expected=0x%08h", name, act, exp));
    endtask

    // one request per rising edge, back to back when called in a row
    task automatic send_req(input logic [31:0] addr, input logic we, input logic [31:0] wd);
        predict_access(addr, we, wd);
        addr_i <= addr;
        wd_i   <= wd;
        we_i   <= we;
        req_i  <= 1'b1;
        @(posedge clk);
    endtask

    task automatic drain_pipeline();
        int guard;
        guard = 0;
        req_i <= 1'b0;
        we_i  <= 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
            guard++;
            if (guard > wait_limit) stop_with_error("timeout while waiting for acknowledges");
        end
    endtask

    task automatic check_pins();
        @(negedge clk);                                         // away from the edge
        check_value("gpio_o", 32'(gpio_o), 32'(model_gpo));
        check_value("gpio_d_o", 32'(gpio_d_o), 32'(model_gpd));
        @(posedge clk);
    endtask

    // response monitor, in request order
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (req_i === 1'b1) begin
            issue_q.push_back(cyc);
            req_cnt = req_cnt + 1;
        end
        if (req_ack_o === 1'b1) begin
            if (issue_q.size() == 0 || exp_rd_q.size() == 0) begin
                stop_with_error("acknowledge seen with no request outstanding");
            end else begin
                check_value("ack_latency", cyc - issue_q[0], ack_lat);
                check_value("rd_o", rd_o, exp_rd_q[0]);
                check_value("resp_err_o", 32'(resp_err_o), 32'(exp_err_q[0]));
                void'(issue_q.pop_front());
                void'(exp_rd_q.pop_front());
                void'(exp_err_q.pop_front());
                ack_cnt = ack_cnt + 1;
            end
        end else if (issue_q.size() != 0 && cyc - issue_q[0] >= ack_lat) begin
            stop_with_error("acknowledge missing for an outstanding request");
        end
    end

    initial begin
        int                                 i;
        int                                 j;
        int                                 high_cnt;
        logic   [31 : 0]                    r;
        logic   [31 : 0]                    addr;
        logic   [31 : 0]                    last_addr;
        logic   [7 : 0]                     w;
        logic   [nf_map_pkg::region_w-1 : 0] region;
        clk = 1'b0;
        reset_i = 1'b1;
        addr_i = '0;
        wd_i = '0;
        we_i = 1'b0;
        req_i = 1'b0;
        gpio_i = '0;
        lfsr_state = lfsr_seed;
        cyc = 0;
        req_cnt = 0;
        ack_cnt = 0;
        model_gpo = '0;
        model_gpd = '0;
        model_gpi = '0;
        model_duty = '0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        for (i = 0; i < 4; i++) begin                           // idle after reset
            @(negedge clk);
            check_value("req_ack_o", 32'(req_ack_o), 32'h0);
            check_value("resp_err_o", 32'(resp_err_o), 32'h0);
            check_value("rd_o", rd_o, 32'h0);
            check_value("pwm_o", 32'(pwm_o), 32'h0);
            check_value("gpio_o", 32'(gpio_o), 32'h0);
            check_value("gpio_d_o", 32'(gpio_d_o), 32'h0);
        end
        @(posedge clk);
        for (i = 0; i < nf_periph_pkg::ram_depth; i++) begin   // RAM starts unknown
            w = i[7:0];
            send_req({22'd0, w, 2'b00}, 1'b1, {w, ~w, w ^ 8'ha5, w + 8'h3c});
        end
        last_addr = '0;
        for (i = 0; i < 200; i++) begin
            r = rand_bits(8);
            addr = last_addr;
            if (r[1:0] == 2'b00) addr[15:10] = r[7:2];          // same word via an alias
            else addr = {16'd0, 14'(rand_bits(14)), 2'b00};
            send_req(addr, next_rand_bit(), rand_bits(32));
            last_addr = addr;
        end
        drain_pipeline();
        for (i = 0; i < 12; i++) begin
            r = rand_bits(8);
            gpio_i <= r[7:0];                                   // held until the next loop
            model_gpi = r[7:0];
            send_req(gpio_base | 32'h4, 1'b1, rand_bits(32));
            drain_pipeline();
            check_pins();
            send_req(gpio_base | 32'h8, 1'b1, rand_bits(32));
            drain_pipeline();
            check_pins();
            for (j = 0; j < 4; j++) send_req(gpio_base | {28'd0, j[1:0], 2'b00}, 1'b0, '0);
            drain_pipeline();
        end
        for (i = 0; i < 6; i++) begin
            send_req(pwm_base, 1'b1, rand_bits(32));
            for (j = 0; j < 4; j++) send_req(pwm_base | {28'd0, j[1:0], 2'b00}, 1'b0, '0);
            drain_pipeline();
            repeat (2) @(posedge clk);                          // duty reaches the compare
            high_cnt = 0;
            j = 0;
            while (j < 256) begin                               // one full counter period
                @(negedge clk);
                if (pwm_o) high_cnt++;
                j++;
            end
            check_value("pwm_high_cycles", high_cnt, 32'(model_duty));
            @(posedge clk);
        end
        for (i = 0; i < 150; i++) begin                         // mixed stream, no gaps
            r = rand_bits(3);
            addr = rand_bits(32);
            region = addr[nf_map_pkg::region_msb : nf_map_pkg::region_lsb];
            if (r[1] == 1'b0) begin
                if (region <= nf_map_pkg::region_pwm) region = region + 4'd3;
            end else if (r[0] == 1'b0) region = nf_map_pkg::region_ram;
            else region = r[2] ? nf_map_pkg::region_pwm : nf_map_pkg::region_gpio;
            addr[nf_map_pkg::region_msb : nf_map_pkg::region_lsb] = region;
            send_req(addr, next_rand_bit(), rand_bits(32));
        end
        drain_pipeline();
        check_pins();
        for (i = 0; i < nf_periph_pkg::ram_depth; i++) send_req({22'd0, i[7:0], 2'b00}, 1'b0, '0);
        for (j = 1; j < 3; j++) send_req(gpio_base | {28'd0, j[1:0], 2'b00}, 1'b0, '0);
        send_req(pwm_base, 1'b0, '0);
        drain_pipeline();
        if (ack_cnt != req_cnt) begin
            stop_with_error($sformatf("MISMATCH ack_count actual=0x%08h expected=0x%08h",
                                      ack_cnt, req_cnt));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule : nf_periph_tb
